/* source/wid_pkg.sv */
`default_nettype none

package wid_pkg;

  // Field widths of the AXI write address channel as seen by the tracker
  localparam int AXI_ID_W   = 8;
  localparam int AXI_LEN_W  = 8;
  localparam int BEAT_CNT_W = 8;

  // Default number of outstanding bursts the table can hold
  localparam int WID_DEPTH_DEFAULT = 32;

  // Transaction ID carried on AWID and tagged onto W as WID
  typedef logic [AXI_ID_W-1:0] axi_id_t;

  // Burst length minus one, same encoding as AWLEN
  typedef logic [AXI_LEN_W-1:0] axi_len_t;

  // Beat number within the burst currently at the head
  typedef logic [BEAT_CNT_W-1:0] beat_cnt_t;

  // One outstanding write burst, ID in the upper byte
  typedef struct packed {
    axi_id_t  id;
    axi_len_t len;
  } wid_entry_t;

endpackage

`default_nettype wire

/* source/aw_id_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module aw_id_capture (
  input  logic                per_clk,
  input  logic                pad_cpu_rst_b,
  input  logic                aw_valid_in,
  input  logic                aw_ready_slave,
  input  wid_pkg::axi_id_t    aw_id,
  input  wid_pkg::axi_len_t   aw_len,
  input  logic                full,
  output logic                aw_valid_slave,
  output logic                aw_ready_master,
  output logic                push,
  output wid_pkg::wid_entry_t push_entry
);

  logic aw_pend_q;   // Valid was up last cycle and not accepted

  // With no free slot the request is hidden from both sides, so the
  // slave cannot accept a burst that the table has no room for
  assign aw_valid_slave  = aw_valid_in && !full;
  assign aw_ready_master = aw_ready_slave && !full;

  assign push = aw_valid_slave && aw_ready_slave;   // One strobe per accepted burst

  assign push_entry.id  = aw_id;
  assign push_entry.len = aw_len;

  always_ff @(posedge per_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      aw_pend_q <= 1'b0;
    else
      aw_pend_q <= aw_valid_in && !push;
  end

  // A pending request must keep its ID and length until it is taken
  a_aw_stable: assert property (
    @(posedge per_clk) disable iff (!pad_cpu_rst_b)
    aw_pend_q && aw_valid_in |-> $stable(aw_id) && $stable(aw_len)
  )
  else
    $error("AW payload changed while the request was pending");

endmodule

`default_nettype wire

/* source/wid_table.sv */
`timescale 1ns/1ps
`default_nettype none

module wid_table #(
  parameter int depth = wid_pkg::WID_DEPTH_DEFAULT
) (
  input  logic                per_clk,
  input  logic                pad_cpu_rst_b,
  input  logic                push,
  input  wid_pkg::wid_entry_t push_entry,
  input  logic                pop,
  output wid_pkg::wid_entry_t head_entry,
  output logic                not_empty,
  output logic                full
);

  import wid_pkg::*;

  localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
  localparam int CNT_W = $clog2(depth + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  wid_entry_t entries [depth];
  ptr_t       create_ptr;
  ptr_t       pop_ptr;
  cnt_t       count;

  // Pointers wrap at depth so any table size works, not only powers of two
  function automatic ptr_t ptr_next(input ptr_t ptr);
    if (ptr == PTR_W'(depth - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  // Slot that the next accepted AW burst is written into
  always_ff @(posedge per_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      create_ptr <= '0;
    else if (push)
      create_ptr <= ptr_next(create_ptr);
  end

  // Oldest outstanding burst, advanced when its last W beat is taken
  always_ff @(posedge per_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      pop_ptr <= '0;
    else if (pop)
      pop_ptr <= ptr_next(pop_ptr);
  end

  always_ff @(posedge per_clk)
  begin
    if (push)
      entries[create_ptr] <= push_entry;
  end

  // Push and pop together leave the occupancy where it was
  always_ff @(posedge per_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      count <= '0;
    else if (push && !pop)
      count <= count + 1'b1;
    else if (pop && !push)
      count <= count - 1'b1;
  end

  assign head_entry = entries[pop_ptr];   // Read mux on the pop pointer
  assign not_empty  = (count != '0);
  assign full       = (count == CNT_W'(depth));

  // The producer masks AW while full, so a push here means the gating broke
  a_no_push_full: assert property (
    @(posedge per_clk) disable iff (!pad_cpu_rst_b)
    push |-> !full
  )
  else
    $error("Push into a full write ID table");

  a_no_pop_empty: assert property (
    @(posedge per_clk) disable iff (!pad_cpu_rst_b)
    pop |-> count != '0
  )
  else
    $error("Pop from an empty write ID table");

  // Occupancy must agree with the distance between the two pointers
  a_ptr_count: assert property (
    @(posedge per_clk) disable iff (!pad_cpu_rst_b)
    (count == '0) || (count == CNT_W'(depth)) |-> create_ptr == pop_ptr
  )
  else
    $error("Table pointers disagree with the occupancy count");

endmodule

`default_nettype wire

/* source/w_burst_tag.sv */
`timescale 1ns/1ps
`default_nettype none

module w_burst_tag (
  input  logic                per_clk,
  input  logic                pad_cpu_rst_b,
  input  logic                w_valid,
  input  logic                w_last,
  input  logic                w_ready,
  input  wid_pkg::wid_entry_t head_entry,
  input  logic                not_empty,
  output wid_pkg::axi_id_t    wid,
  output logic                wid_valid,
  output logic                pop,
  output logic                len_err,
  output logic                orphan_err
);

  import wid_pkg::*;

  beat_cnt_t beat_cnt;   // Beats already taken in the head burst
  logic      w_taken;
  logic      w_tracked;  // Taken beat that belongs to a known burst
  logic      at_len;

  // The head ID goes straight out so W sees it in the same cycle
  assign wid       = head_entry.id;
  assign wid_valid = not_empty;

  assign w_taken   = w_valid && w_ready;
  assign w_tracked = w_taken && not_empty;
  assign at_len    = (beat_cnt == head_entry.len);

  // Last beat retires the head even when the length was wrong
  assign pop = w_tracked && w_last;

  // Early last beat or a missing last on the final beat are both flagged
  always_comb
  begin
    len_err = 1'b0;
    if (w_tracked)
    begin
      if (w_last)
        len_err = !at_len;
      else
        len_err = at_len;
    end
  end

  assign orphan_err = w_taken && !not_empty;   // W data ahead of its address

  always_ff @(posedge per_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      beat_cnt <= '0;
    else if (w_tracked)
    begin
      if (w_last)
        beat_cnt <= '0;
      else
        beat_cnt <= beat_cnt + 1'b1;
    end
  end

  a_pop_has_head: assert property (
    @(posedge per_clk) disable iff (!pad_cpu_rst_b)
    pop |-> not_empty
  )
  else
    $error("Burst retired with no entry at the table head");

endmodule

`default_nettype wire

/* source/wid_tracker_top.sv */
`timescale 1ns/1ps
`default_nettype none

module wid_tracker_top #(
  parameter int depth = wid_pkg::WID_DEPTH_DEFAULT
) (
  input  logic              per_clk,
  input  logic              pad_cpu_rst_b,
  input  logic              biu_pad_awvalid,
  input  wid_pkg::axi_id_t  biu_pad_awid,
  input  wid_pkg::axi_len_t biu_pad_awlen,
  input  logic              pad_biu_awready,
  output logic              pad_awvalid_out,
  output logic              biu_awready_out,
  input  logic              biu_pad_wvalid,
  input  logic              biu_pad_wlast,
  input  logic              pad_biu_wready,
  output wid_pkg::axi_id_t  biu_pad_wid,
  output logic              biu_pad_wid_valid,
  output logic              len_err,
  output logic              orphan_err
);

  import wid_pkg::*;

  logic       push;
  logic       pop;
  logic       full;
  logic       not_empty;
  wid_entry_t push_entry;
  wid_entry_t head_entry;

  aw_id_capture u_aw_id_capture (
    .per_clk         (per_clk),
    .pad_cpu_rst_b   (pad_cpu_rst_b),
    .aw_valid_in     (biu_pad_awvalid),
    .aw_ready_slave  (pad_biu_awready),
    .aw_id           (biu_pad_awid),
    .aw_len          (biu_pad_awlen),
    .full            (full),
    .aw_valid_slave  (pad_awvalid_out),
    .aw_ready_master (biu_awready_out),
    .push            (push),
    .push_entry      (push_entry)
  );

  wid_table #(
    .depth (depth)
  ) u_wid_table (
    .per_clk       (per_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .push          (push),
    .push_entry    (push_entry),
    .pop           (pop),
    .head_entry    (head_entry),
    .not_empty     (not_empty),
    .full          (full)
  );

  w_burst_tag u_w_burst_tag (
    .per_clk       (per_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .w_valid       (biu_pad_wvalid),
    .w_last        (biu_pad_wlast),
    .w_ready       (pad_biu_wready),
    .head_entry    (head_entry),
    .not_empty     (not_empty),
    .wid           (biu_pad_wid),
    .wid_valid     (biu_pad_wid_valid),
    .pop           (pop),
    .len_err       (len_err),
    .orphan_err    (orphan_err)
  );

endmodule

`default_nettype wire

/* testbench/tb_wid_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_wid_tracker;

  import wid_pkg::*;

  localparam int DEPTH          = 32;
  localparam int RANDOM_BURSTS  = 150;
  localparam int ERROR_ROUNDS   = 12;
  localparam int TIMEOUT_CYCLES = 2000;

  logic     per_clk;
  logic     pad_cpu_rst_b;
  logic     biu_pad_awvalid;
  axi_id_t  biu_pad_awid;
  axi_len_t biu_pad_awlen;
  logic     pad_biu_awready;
  logic     pad_awvalid_out;
  logic     biu_awready_out;
  logic     biu_pad_wvalid;
  logic     biu_pad_wlast;
  logic     pad_biu_wready;
  axi_id_t  biu_pad_wid;
  logic     biu_pad_wid_valid;
  logic     len_err;
  logic     orphan_err;

  int unsigned rng_state;
  logic        ready_random;   // Slave ready toggles at random when set
  axi_len_t    w_plan [$];     // Lengths of accepted bursts still owed W data

  // Reference model of the outstanding bursts in AW order
  wid_entry_t model_q [$];
  int         model_size;
  axi_id_t    exp_id;
  axi_len_t   exp_len;
  beat_cnt_t  model_beat;

  int n_tagged;
  int n_len_err;
  int n_orphan;
  int n_full_hold;

  logic w_taken;
  logic exp_len_err;
  logic exp_orphan;
  int   beat_num;    // Position of the current W beat in the head burst, from one
  int   due_beats;

  wid_tracker_top #(
    .depth (DEPTH)
  ) UUT (
    .per_clk           (per_clk),
    .pad_cpu_rst_b     (pad_cpu_rst_b),
    .biu_pad_awvalid   (biu_pad_awvalid),
    .biu_pad_awid      (biu_pad_awid),
    .biu_pad_awlen     (biu_pad_awlen),
    .pad_biu_awready   (pad_biu_awready),
    .pad_awvalid_out   (pad_awvalid_out),
    .biu_awready_out   (biu_awready_out),
    .biu_pad_wvalid    (biu_pad_wvalid),
    .biu_pad_wlast     (biu_pad_wlast),
    .pad_biu_wready    (pad_biu_wready),
    .biu_pad_wid       (biu_pad_wid),
    .biu_pad_wid_valid (biu_pad_wid_valid),
    .len_err           (len_err),
    .orphan_err        (orphan_err)
  );

  initial
  begin
    per_clk = 1'b0;
    forever
      #2 per_clk = ~per_clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    rng_state = rng_state * 1103515245 + 12345;
    return (rng_state >> 16) % n;
  endfunction

  assign w_taken    = biu_pad_wvalid && pad_biu_wready;
  assign exp_orphan = w_taken && (model_size == 0);
  assign beat_num   = int'(model_beat) + 1;
  assign due_beats  = int'(exp_len) + 1;   // AWLEN holds the beat count minus one

  // Only the beat numbered len + 1 may carry wlast, and it must
  assign exp_len_err = w_taken && (model_size != 0) &&
                       (biu_pad_wlast ? (beat_num != due_beats) : (beat_num == due_beats));

  always @(posedge per_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      model_q.delete();
      model_size  <= 0;
      exp_id      <= '0;
      exp_len     <= '0;
      model_beat  <= '0;
      n_tagged    <= 0;
      n_len_err   <= 0;
      n_orphan    <= 0;
      n_full_hold <= 0;
    end
    else
    begin
      if (w_taken && model_q.size() != 0)
      begin
        n_tagged <= n_tagged + 1;
        if (biu_pad_wlast)
        begin
          void'(model_q.pop_front());
          model_beat <= '0;
        end
        else
          model_beat <= model_beat + 1'b1;
      end
      if (pad_awvalid_out && pad_biu_awready)
        model_q.push_back({biu_pad_awid, biu_pad_awlen});
      if (exp_len_err)
        n_len_err <= n_len_err + 1;
      if (exp_orphan)
        n_orphan <= n_orphan + 1;
      if (model_size == DEPTH && biu_pad_awvalid)
        n_full_hold <= n_full_hold + 1;
      model_size <= model_q.size();
      if (model_q.size() != 0)
      begin
        exp_id  <= model_q[0].id;
        exp_len <= model_q[0].len;
      end
    end
  end

  a_reset_quiet: assert property (
    @(posedge per_clk)
    !pad_cpu_rst_b || $rose(pad_cpu_rst_b) |-> !biu_pad_wid_valid && !len_err && !orphan_err
  )
  else
    report_failure($sformatf("Fail reset outputs: wid_valid %h len_err %h orphan_err %h",
                             $sampled(biu_pad_wid_valid), $sampled(len_err),
                             $sampled(orphan_err)));

  a_wid_valid: assert property (
    @(posedge per_clk) disable iff (!pad_cpu_rst_b)
    biu_pad_wid_valid == (model_size != 0)
  )
  else
    report_failure($sformatf("Fail biu_pad_wid_valid: got %h, expected %h",
                             $sampled(biu_pad_wid_valid), $sampled(model_size != 0)));

  a_wid_match: assert property (
    @(posedge per_clk) disable iff (!pad_cpu_rst_b)
    w_taken && model_size != 0 |-> biu_pad_wid == exp_id
  )
  else
    report_failure($sformatf("Fail biu_pad_wid: got %h, expected %h",
                             $sampled(biu_pad_wid), $sampled(exp_id)));

  a_full_block: assert property (
    @(posedge per_clk) disable iff (!pad_cpu_rst_b)
    model_size == DEPTH && biu_pad_awvalid |-> !biu_awready_out && !pad_awvalid_out
  )
  else
    report_failure($sformatf("Fail biu_awready_out/pad_awvalid_out: got %h/%h, expected 0/0",
                             $sampled(biu_awready_out), $sampled(pad_awvalid_out)));

  // Below full the address channel passes straight through
  a_aw_open: assert property (
    @(posedge per_clk) disable iff (!pad_cpu_rst_b)
    model_size < DEPTH |-> pad_awvalid_out == biu_pad_awvalid &&
                           biu_awready_out == pad_biu_awready
  )
  else
    report_failure($sformatf("Fail pad_awvalid_out/biu_awready_out: got %h/%h, expected %h/%h",
                             $sampled(pad_awvalid_out), $sampled(biu_awready_out),
                             $sampled(biu_pad_awvalid), $sampled(pad_biu_awready)));

  a_len_err: assert property (
    @(posedge per_clk) disable iff (!pad_cpu_rst_b)
    len_err == exp_len_err
  )
  else
    report_failure($sformatf("Fail len_err: got %h, expected %h",
                             $sampled(len_err), $sampled(exp_len_err)));

  a_orphan_err: assert property (
    @(posedge per_clk) disable iff (!pad_cpu_rst_b)
    orphan_err == exp_orphan
  )
  else
    report_failure($sformatf("Fail orphan_err: got %h, expected %h",
                             $sampled(orphan_err), $sampled(exp_orphan)));

  initial
  begin
    pad_biu_awready = 1'b0;
    pad_biu_wready  = 1'b0;
    forever
    begin
      @(negedge per_clk);
      if (ready_random)
      begin
        pad_biu_awready = (rand_below(4) != 0);
        pad_biu_wready  = (rand_below(4) != 0);
      end
      else
      begin
        pad_biu_awready = 1'b1;
        pad_biu_wready  = 1'b1;
      end
    end
  end

  // Called on a falling edge and returns on the falling edge after acceptance
  task automatic send_aw(input axi_id_t id, input axi_len_t len);
    int   waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    biu_pad_awvalid = 1'b1;
    biu_pad_awid    = id;
    biu_pad_awlen   = len;
    while (!accepted)
    begin
      if (waited == TIMEOUT_CYCLES)
        report_failure("Timed out waiting for an AW handshake");
      @(posedge per_clk);
      accepted = pad_awvalid_out && pad_biu_awready;
      waited++;
      @(negedge per_clk);
    end
    biu_pad_awvalid = 1'b0;
    w_plan.push_back(len);
  endtask

  // A shift of -1 ends the burst a beat early, +1 a beat late
  task automatic send_w_burst(input axi_len_t len, input int shift);
    int   beats;
    int   beat;
    int   waited;
    logic taken;
    beats = int'(len) + 1 + shift;
    for (beat = 0; beat < beats; beat++)
    begin
      biu_pad_wvalid = 1'b0;
      repeat (rand_below(2)) @(negedge per_clk);
      biu_pad_wvalid = 1'b1;
      biu_pad_wlast  = (beat == beats - 1);
      waited = 0;
      taken  = 1'b0;
      while (!taken)
      begin
        if (waited == TIMEOUT_CYCLES)
          report_failure("Timed out waiting for a W beat to be taken");
        @(posedge per_clk);
        taken = biu_pad_wvalid && pad_biu_wready;
        waited++;
        @(negedge per_clk);
      end
    end
    biu_pad_wvalid = 1'b0;
    biu_pad_wlast  = 1'b0;
  endtask

  task automatic drain_bursts(input int count);
    int       sent;
    int       waited;
    axi_len_t len;
    sent = 0;
    while (sent < count)
    begin
      waited = 0;
      while (w_plan.size() == 0)
      begin
        if (waited == TIMEOUT_CYCLES)
          report_failure("Timed out waiting for a burst address to be accepted");
        waited++;
        @(negedge per_clk);
      end
      len = w_plan.pop_front();
      send_w_burst(len, 0);
      sent++;
    end
  endtask

  task automatic wait_table_empty();
    int waited;
    waited = 0;
    while (model_size != 0)
    begin
      if (waited == TIMEOUT_CYCLES)
        report_failure("Timed out waiting for the write ID table to drain");
      waited++;
      @(negedge per_clk);
    end
  endtask

  initial
  begin
    int       i;
    int       k;
    int       kind;
    axi_len_t len;
    rng_state       = 68777;
    ready_random    = 1'b1;
    pad_cpu_rst_b   = 1'b0;
    biu_pad_awvalid = 1'b0;
    biu_pad_awid    = '0;
    biu_pad_awlen   = '0;
    biu_pad_wvalid  = 1'b0;
    biu_pad_wlast   = 1'b0;
    repeat (4) @(negedge per_clk);
    pad_cpu_rst_b = 1'b1;
    @(negedge per_clk);

    // Overlapping AW and W traffic with stalls on both sides
    fork
      begin
        for (i = 0; i < RANDOM_BURSTS; i++)
        begin
          repeat (rand_below(3)) @(negedge per_clk);
          send_aw(axi_id_t'(rand_below(4)), axi_len_t'(rand_below(4)));
        end
      end
      drain_bursts(RANDOM_BURSTS);
    join

    // Fill every slot, then hold one more request against the full table
    ready_random = 1'b0;
    wait_table_empty();
    @(negedge per_clk);
    for (i = 0; i < DEPTH; i++)
      send_aw(axi_id_t'(rand_below(4)), axi_len_t'(rand_below(4)));
    fork
      send_aw(axi_id_t'(rand_below(4)), axi_len_t'(rand_below(4)));
      begin
        repeat (6) @(negedge per_clk);
        drain_bursts(DEPTH + 1);
      end
    join

    ready_random = 1'b1;
    for (k = 0; k < ERROR_ROUNDS; k++)
    begin
      kind = (k < 3) ? k : int'(rand_below(3));
      wait_table_empty();
      case (kind)
        0:
        begin
          len = axi_len_t'(1 + rand_below(3));
          send_aw(axi_id_t'(rand_below(4)), len);
          void'(w_plan.pop_front());
          send_w_burst(len, -1);
        end
        1:
        begin
          len = axi_len_t'(rand_below(4));
          send_aw(axi_id_t'(rand_below(4)), len);
          void'(w_plan.pop_front());
          send_w_burst(len, 1);
        end
        default:
          send_w_burst(8'd0, 0);   // Lone beat with no address ahead of it
      endcase
      repeat (rand_below(3)) @(negedge per_clk);
    end
    wait_table_empty();
    repeat (2) @(negedge per_clk);

    if (n_orphan > 0 && n_len_err > 1 && n_full_hold > 0 && n_tagged > RANDOM_BURSTS)
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
    else
      report_failure("The stimulus did not reach every checked behavior");
  end

endmodule

`default_nettype wire

/* list.f */
source/wid_pkg.sv
source/aw_id_capture.sv
source/wid_table.sv
source/w_burst_tag.sv
source/wid_tracker_top.sv
testbench/tb_wid_tracker.sv

/* Makefile */
TOP := tb_wid_tracker
SIM := obj_dir/V$(TOP)

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): list.f $(shell cat list.f)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f list.f -o V$(TOP)

clean:
	rm -rf obj_dir
